// File: floo_nw_router.f
hw/floo_nw_pkg.sv
hw/floo_link_if.sv
hw/floo_in_port.sv
hw/floo_out_arbiter.sv
hw/floo_router.sv
hw/floo_nw_router.sv
verification/floo_nw_router_properties.sv
verification/floo_nw_router_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= floo_nw_router_tb
RTL_TOP   ?= floo_nw_router
FILELIST  ?= floo_nw_router.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/floo_nw_router_tb.sv
// --------------------
// Testbench for the three-network router node: clock, reset,
// stimulus, scoreboard, watchdog and final report
// --------------------

module floo_nw_router_tb;
  import floo_nw_pkg::*;

  localparam int Burst      = 8;
  localparam int BpFlits    = 6;
  localparam int IndepBurst = 4;
  localparam int TotalFlits = 3 * NumPorts * Burst + 2 * BpFlits + 4 * Burst
                              + NumPorts + 2 * NumPorts * IndepBurst;
  localparam coord_t NodeX = 3'd3;
  localparam coord_t NodeY = 3'd3;

  logic clk;
  logic reset;
  logic   [NumPorts-1:0] in_valid [3];
  logic   [NumPorts-1:0] in_ready [3];
  logic   [NumPorts-1:0] out_valid [3];
  logic   [NumPorts-1:0] out_ready [3];
  coord_t [NumPorts-1:0] in_dx [3];
  coord_t [NumPorts-1:0] in_dy [3];
  coord_t [NumPorts-1:0] out_dx [3];
  coord_t [NumPorts-1:0] out_dy [3];
  req_payload_t  [NumPorts-1:0] req_ipl, req_opl;
  rsp_payload_t  [NumPorts-1:0] rsp_ipl, rsp_opl;
  wide_payload_t [NumPorts-1:0] wide_ipl, wide_opl;

  // One queue per network, input and output; entries are {dst_x, dst_y, payload}
  logic [133:0] sb [3*NumPorts*NumPorts][$];
  int seed = 32'h4d82;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  bit fair_on = 1'b0;
  int gap [NumPorts];

  floo_nw_router dut0 (
    .clk_i (clk), .reset_i (reset), .node_x_i (NodeX), .node_y_i (NodeY),
    .req_in_valid_i (in_valid[0]), .req_in_ready_o (in_ready[0]),
    .req_in_dst_x_i (in_dx[0]), .req_in_dst_y_i (in_dy[0]), .req_in_payload_i (req_ipl),
    .req_out_valid_o (out_valid[0]), .req_out_ready_i (out_ready[0]),
    .req_out_dst_x_o (out_dx[0]), .req_out_dst_y_o (out_dy[0]), .req_out_payload_o (req_opl),
    .rsp_in_valid_i (in_valid[1]), .rsp_in_ready_o (in_ready[1]),
    .rsp_in_dst_x_i (in_dx[1]), .rsp_in_dst_y_i (in_dy[1]), .rsp_in_payload_i (rsp_ipl),
    .rsp_out_valid_o (out_valid[1]), .rsp_out_ready_i (out_ready[1]),
    .rsp_out_dst_x_o (out_dx[1]), .rsp_out_dst_y_o (out_dy[1]), .rsp_out_payload_o (rsp_opl),
    .wide_in_valid_i (in_valid[2]), .wide_in_ready_o (in_ready[2]),
    .wide_in_dst_x_i (in_dx[2]), .wide_in_dst_y_i (in_dy[2]), .wide_in_payload_i (wide_ipl),
    .wide_out_valid_o (out_valid[2]), .wide_out_ready_i (out_ready[2]),
    .wide_out_dst_x_o (out_dx[2]), .wide_out_dst_y_o (out_dy[2]),
    .wide_out_payload_o (wide_opl)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // XY rule at node (3,3) with X resolved before Y
  // Port numbers follow port_e
  function automatic int xy_port(coord_t dx, coord_t dy);
    if (dx > NodeX) return 2;
    if (dx < NodeX) return 4;
    if (dy > NodeY) return 1;
    if (dy < NodeY) return 3;
    return 0;
  endfunction

  function automatic int sb_idx(int n, int s, int o);
    return (n * NumPorts + s) * NumPorts + o;
  endfunction

  function automatic int pending(int n);
    int total;
    total = 0;
    for (int i = 0; i < NumPorts * NumPorts; i++) total += sb[n * NumPorts * NumPorts + i].size();
    return total;
  endfunction

  function automatic logic [127:0] out_pl(int n, int o);
    case (n)
      0: return 128'(req_opl[o]);
      1: return 128'(rsp_opl[o]);
      default: return wide_opl[o];
    endcase
  endfunction

  // Caller is just past a falling edge; valid is held until the flit is taken
  task automatic send(int n, int p, coord_t dx, coord_t dy);
    logic [127:0] pl;
    bit done;
    pl = {$random(seed), $random(seed), $random(seed), $random(seed)};
    if (n == 0) pl = pl & 128'hffff_ffff;
    if (n == 1) pl = pl & 128'hffff;
    pl[2:0] = p[2:0];
    in_dx[n][p] = dx;
    in_dy[n][p] = dy;
    case (n)
      0: req_ipl[p] = pl[31:0];
      1: rsp_ipl[p] = pl[15:0];
      default: wide_ipl[p] = pl;
    endcase
    in_valid[n][p] = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (in_ready[n][p]) begin
        done = 1'b1;
        sb[sb_idx(n, p, xy_port(dx, dy))].push_back({dx, dy, pl});
      end
      @(negedge clk);
    end
    in_valid[n][p] = 1'b0;
  endtask

  // A negative coordinate draws a random one
  task automatic burst(int n, int p, int cnt, int dx, int dy);
    for (int k = 0; k < cnt; k++) begin
      send(n, p, (dx < 0) ? coord_t'($random(seed)) : coord_t'(dx),
           (dy < 0) ? coord_t'($random(seed)) : coord_t'(dy));
    end
  endtask

  task automatic wait_drain(int n);
    while (pending(n) > 0) @(negedge clk);
  endtask

  task automatic test_done(string name);
    tests++;
    $display("Test %0d %s finished, errors so far %0d", tests, name, errors);
  endtask

  task automatic check_out(int n, int o);
    logic [133:0] got;
    logic [133:0] exp;
    int src;
    got = {out_dx[n][o], out_dy[n][o], out_pl(n, o)};
    src = int'(got[2:0]);
    checks++;
    assert (xy_port(out_dx[n][o], out_dy[n][o]) == o) else begin
      errors++;
      $display("ERR %0t net%0d out_port expected %0d actual %0d", $time, n,
               xy_port(out_dx[n][o], out_dy[n][o]), o);
    end
    if (src >= NumPorts || sb[sb_idx(n, src, o)].size() == 0) begin
      errors++;
      $display("At %0t net %0d port %0d delivered a flit that was never sent", $time, n, o);
    end else begin
      exp = sb[sb_idx(n, src, o)].pop_front();
      assert (got == exp) else begin
        errors++;
        $display("ERR %0t net%0d out_flit[%0d] expected %h actual %h", $time, n, o, exp, got);
      end
    end
    if (fair_on && n == 0 && o == 0 && src < NumPorts) begin
      assert (gap[src] <= NumPorts - 1) else begin
        errors++;
        $display("ERR %0t req grant_gap[%0d] expected <= %0d actual %0d", $time, src,
                 NumPorts - 1, gap[src]);
      end
      for (int k = 1; k < NumPorts; k++) gap[k]++;
      gap[src] = 0;
    end
  endtask

  // Outputs sampled on the rising edge, where they are stable
  always @(posedge clk) begin
    if (!reset) begin
      for (int n = 0; n < 3; n++) begin
        for (int o = 0; o < NumPorts; o++) begin
          if (out_valid[n][o] && out_ready[n][o]) check_out(n, o);
        end
      end
    end
  end

  initial begin
    repeat (20 * TotalFlits) @(posedge clk);
    $display("Timeout: traffic did not drain within %0d cycles", 20 * TotalFlits);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    port_sel_t wide_mask;
    coord_t    wide_dx;
    reset = 1'b1;
    for (int n = 0; n < 3; n++) begin
      in_valid[n]  = '0;
      out_ready[n] = '1;
      in_dx[n]     = '0;
      in_dy[n]     = '0;
    end
    req_ipl  = '0;
    rsp_ipl  = '0;
    wide_ipl = '0;
    for (int k = 0; k < NumPorts; k++) gap[k] = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    for (int n = 0; n < 3; n++) begin
      assert (out_valid[n] == '0 && in_ready[n] == '1) else begin
        errors++;
        $display("ERR %0t net%0d out_valid/in_ready expected 00000/11111 actual %b/%b",
                 $time, n, out_valid[n], in_ready[n]);
      end
    end
    test_done("reset");

    // Random traffic on every input of every network
    for (int n = 0; n < 3; n++) begin
      for (int p = 0; p < NumPorts; p++) begin
        fork
          automatic int nn = n;
          automatic int pp = p;
          burst(nn, pp, Burst, -1, -1);
        join_none
      end
    end
    wait fork;
    for (int n = 0; n < 3; n++) wait_drain(n);
    test_done("routing and ordering");

    // Stall the request and response East outputs while Local keeps sending to them
    out_ready[0][2] = 1'b0;
    out_ready[1][2] = 1'b0;
    fork
      burst(0, 0, BpFlits, 5, 3);
      burst(1, 0, BpFlits, 5, 3);
    join_none
    repeat (12) @(negedge clk);
    for (int n = 0; n < 2; n++) begin
      assert (out_valid[n][2] && !in_ready[n][0]) else begin
        errors++;
        $display("Back-pressure did not fill the Local input buffer of network %0d", n);
      end
    end
    out_ready[0][2] = 1'b1;
    out_ready[1][2] = 1'b1;
    wait fork;
    wait_drain(0);
    wait_drain(1);
    test_done("back-pressure");

    // North, East, South and West all aim at the request Local output
    fair_on = 1'b1;
    for (int p = 1; p < NumPorts; p++) begin
      fork
        automatic int pp = p;
        burst(0, pp, Burst, 3, 3);
      join_none
    end
    wait fork;
    wait_drain(0);
    fair_on = 1'b0;
    test_done("fairness");

    // Wide network stalled, request and response keep flowing
    out_ready[2] = '0;
    wide_mask = '0;
    for (int p = 0; p < NumPorts; p++) begin
      wide_dx = coord_t'($random(seed));
      wide_mask[xy_port(wide_dx, coord_t'(p))] = 1'b1;
      send(2, p, wide_dx, coord_t'(p));
    end
    for (int n = 0; n < 2; n++) begin
      for (int p = 0; p < NumPorts; p++) begin
        fork
          automatic int nn = n;
          automatic int pp = p;
          burst(nn, pp, IndepBurst, -1, -1);
        join_none
      end
    end
    wait fork;
    wait_drain(0);
    wait_drain(1);
    // Every wide output named by a stalled flit holds it
    assert (out_valid[2] == wide_mask) else begin
      errors++;
      $display("ERR %0t wide_out_valid expected %b actual %b", $time, wide_mask, out_valid[2]);
    end
    out_ready[2] = '1;
    wait_drain(2);
    test_done("independence");

    repeat (3) @(negedge clk);
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verification/floo_nw_router_properties.sv
// --------------------
// Handshake properties on the router node outputs,
// bound to the top level
// --------------------

module floo_nw_router_properties (
  input logic                                                  clk_i,
  input logic                                                  reset_i,
  input logic [floo_nw_pkg::NumPorts-1:0]                      req_in_valid_i,
  input logic [floo_nw_pkg::NumPorts-1:0]                      req_in_ready_o,
  input logic [floo_nw_pkg::NumPorts-1:0]                      req_out_valid_o,
  input logic [floo_nw_pkg::NumPorts-1:0]                      req_out_ready_i,
  input floo_nw_pkg::req_payload_t [floo_nw_pkg::NumPorts-1:0] req_out_payload_o,
  input floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       req_out_dst_x_o,
  input floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       req_out_dst_y_o,
  input logic [floo_nw_pkg::NumPorts-1:0]                      rsp_in_ready_o,
  input logic [floo_nw_pkg::NumPorts-1:0]                      rsp_out_valid_o,
  input logic [floo_nw_pkg::NumPorts-1:0]                      rsp_out_ready_i,
  input floo_nw_pkg::rsp_payload_t [floo_nw_pkg::NumPorts-1:0] rsp_out_payload_o,
  input floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       rsp_out_dst_x_o,
  input floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       rsp_out_dst_y_o,
  input logic [floo_nw_pkg::NumPorts-1:0]                      wide_in_ready_o,
  input logic [floo_nw_pkg::NumPorts-1:0]                      wide_out_valid_o,
  input logic [floo_nw_pkg::NumPorts-1:0]                      wide_out_ready_i,
  input floo_nw_pkg::wide_payload_t [floo_nw_pkg::NumPorts-1:0] wide_out_payload_o,
  input floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       wide_out_dst_x_o,
  input floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       wide_out_dst_y_o
);
  import floo_nw_pkg::*;

  logic req_seen_q;

  // Any request input transfer since reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_seen_q <= 1'b0;
    end else if ((req_in_valid_i & req_in_ready_o) != '0) begin
      req_seen_q <= 1'b1;
    end
  end

  a_idle_after_reset: assert property (@(posedge clk_i) disable iff (reset_i)
    !req_seen_q |-> req_out_valid_o == '0) else $error("request output valid before any input");

  a_ready_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> &{req_in_ready_o, rsp_in_ready_o, wide_in_ready_o})
    else $error("input ready low after reset");

  for (genvar i = 0; i < NumPorts; i++) begin : gen_hold
    a_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      req_out_valid_o[i] && !req_out_ready_i[i] |=> req_out_valid_o[i]
        && $stable(req_out_payload_o[i]) && $stable(req_out_dst_x_o[i])
        && $stable(req_out_dst_y_o[i]))
      else $error("request output flit changed while stalled");
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_out_valid_o[i] && !rsp_out_ready_i[i] |=> rsp_out_valid_o[i]
        && $stable(rsp_out_payload_o[i]) && $stable(rsp_out_dst_x_o[i])
        && $stable(rsp_out_dst_y_o[i]))
      else $error("response output flit changed while stalled");
    a_wide_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      wide_out_valid_o[i] && !wide_out_ready_i[i] |=> wide_out_valid_o[i]
        && $stable(wide_out_payload_o[i]) && $stable(wide_out_dst_x_o[i])
        && $stable(wide_out_dst_y_o[i]))
      else $error("wide output flit changed while stalled");
  end

endmodule

bind floo_nw_router floo_nw_router_properties props0 (.*);

// File: hw/floo_nw_router.sv
// --------------------
// Router node top: request, response and wide networks
// --------------------

module floo_nw_router (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  floo_nw_pkg::coord_t                                   node_x_i,
  input  floo_nw_pkg::coord_t                                   node_y_i,
  // Request network
  input  logic [floo_nw_pkg::NumPorts-1:0]                      req_in_valid_i,
  output logic [floo_nw_pkg::NumPorts-1:0]                      req_in_ready_o,
  input  floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       req_in_dst_x_i,
  input  floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       req_in_dst_y_i,
  input  floo_nw_pkg::req_payload_t [floo_nw_pkg::NumPorts-1:0] req_in_payload_i,
  output logic [floo_nw_pkg::NumPorts-1:0]                      req_out_valid_o,
  input  logic [floo_nw_pkg::NumPorts-1:0]                      req_out_ready_i,
  output floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       req_out_dst_x_o,
  output floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       req_out_dst_y_o,
  output floo_nw_pkg::req_payload_t [floo_nw_pkg::NumPorts-1:0] req_out_payload_o,
  // Response network
  input  logic [floo_nw_pkg::NumPorts-1:0]                      rsp_in_valid_i,
  output logic [floo_nw_pkg::NumPorts-1:0]                      rsp_in_ready_o,
  input  floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       rsp_in_dst_x_i,
  input  floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       rsp_in_dst_y_i,
  input  floo_nw_pkg::rsp_payload_t [floo_nw_pkg::NumPorts-1:0] rsp_in_payload_i,
  output logic [floo_nw_pkg::NumPorts-1:0]                      rsp_out_valid_o,
  input  logic [floo_nw_pkg::NumPorts-1:0]                      rsp_out_ready_i,
  output floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       rsp_out_dst_x_o,
  output floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       rsp_out_dst_y_o,
  output floo_nw_pkg::rsp_payload_t [floo_nw_pkg::NumPorts-1:0] rsp_out_payload_o,
  // Wide network
  input  logic [floo_nw_pkg::NumPorts-1:0]                      wide_in_valid_i,
  output logic [floo_nw_pkg::NumPorts-1:0]                      wide_in_ready_o,
  input  floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       wide_in_dst_x_i,
  input  floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       wide_in_dst_y_i,
  input  floo_nw_pkg::wide_payload_t [floo_nw_pkg::NumPorts-1:0] wide_in_payload_i,
  output logic [floo_nw_pkg::NumPorts-1:0]                      wide_out_valid_o,
  input  logic [floo_nw_pkg::NumPorts-1:0]                      wide_out_ready_i,
  output floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       wide_out_dst_x_o,
  output floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0]       wide_out_dst_y_o,
  output floo_nw_pkg::wide_payload_t [floo_nw_pkg::NumPorts-1:0] wide_out_payload_o
);
  import floo_nw_pkg::*;

  floo_link_if #(.PayloadW(ReqPayloadW))  req_in_link   [NumPorts] ();
  floo_link_if #(.PayloadW(ReqPayloadW))  req_out_link  [NumPorts] ();
  floo_link_if #(.PayloadW(RspPayloadW))  rsp_in_link   [NumPorts] ();
  floo_link_if #(.PayloadW(RspPayloadW))  rsp_out_link  [NumPorts] ();
  floo_link_if #(.PayloadW(WidePayloadW)) wide_in_link  [NumPorts] ();
  floo_link_if #(.PayloadW(WidePayloadW)) wide_out_link [NumPorts] ();

  // Plain port arrays onto the link bundles
  for (genvar i = 0; i < NumPorts; i++) begin : gen_links
    assign req_in_link[i].valid    = req_in_valid_i[i];
    assign req_in_link[i].dst_x    = req_in_dst_x_i[i];
    assign req_in_link[i].dst_y    = req_in_dst_y_i[i];
    assign req_in_link[i].payload  = req_in_payload_i[i];
    assign req_in_ready_o[i]       = req_in_link[i].ready;
    assign req_out_valid_o[i]      = req_out_link[i].valid;
    assign req_out_dst_x_o[i]      = req_out_link[i].dst_x;
    assign req_out_dst_y_o[i]      = req_out_link[i].dst_y;
    assign req_out_payload_o[i]    = req_out_link[i].payload;
    assign req_out_link[i].ready   = req_out_ready_i[i];

    assign rsp_in_link[i].valid    = rsp_in_valid_i[i];
    assign rsp_in_link[i].dst_x    = rsp_in_dst_x_i[i];
    assign rsp_in_link[i].dst_y    = rsp_in_dst_y_i[i];
    assign rsp_in_link[i].payload  = rsp_in_payload_i[i];
    assign rsp_in_ready_o[i]       = rsp_in_link[i].ready;
    assign rsp_out_valid_o[i]      = rsp_out_link[i].valid;
    assign rsp_out_dst_x_o[i]      = rsp_out_link[i].dst_x;
    assign rsp_out_dst_y_o[i]      = rsp_out_link[i].dst_y;
    assign rsp_out_payload_o[i]    = rsp_out_link[i].payload;
    assign rsp_out_link[i].ready   = rsp_out_ready_i[i];

    assign wide_in_link[i].valid   = wide_in_valid_i[i];
    assign wide_in_link[i].dst_x   = wide_in_dst_x_i[i];
    assign wide_in_link[i].dst_y   = wide_in_dst_y_i[i];
    assign wide_in_link[i].payload = wide_in_payload_i[i];
    assign wide_in_ready_o[i]      = wide_in_link[i].ready;
    assign wide_out_valid_o[i]     = wide_out_link[i].valid;
    assign wide_out_dst_x_o[i]     = wide_out_link[i].dst_x;
    assign wide_out_dst_y_o[i]     = wide_out_link[i].dst_y;
    assign wide_out_payload_o[i]   = wide_out_link[i].payload;
    assign wide_out_link[i].ready  = wide_out_ready_i[i];
  end

  // Three independent networks, same node coordinate
  floo_router #(
    .PayloadW ( ReqPayloadW )
  ) i_req_router (
    .clk_i,
    .reset_i,
    .node_x_i,
    .node_y_i,
    .in_link  ( req_in_link  ),
    .out_link ( req_out_link )
  );

  floo_router #(
    .PayloadW ( RspPayloadW )
  ) i_rsp_router (
    .clk_i,
    .reset_i,
    .node_x_i,
    .node_y_i,
    .in_link  ( rsp_in_link  ),
    .out_link ( rsp_out_link )
  );

  floo_router #(
    .PayloadW ( WidePayloadW )
  ) i_wide_router (
    .clk_i,
    .reset_i,
    .node_x_i,
    .node_y_i,
    .in_link  ( wide_in_link  ),
    .out_link ( wide_out_link )
  );

endmodule

// File: hw/floo_router.sv
// --------------------
// Five-port router for one physical network
// --------------------

module floo_router #(
  parameter int unsigned PayloadW = 32
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  floo_nw_pkg::coord_t node_x_i,
  input  floo_nw_pkg::coord_t node_y_i,
  floo_link_if.receiver       in_link  [floo_nw_pkg::NumPorts],
  floo_link_if.sender         out_link [floo_nw_pkg::NumPorts]
);
  import floo_nw_pkg::*;

  // Indexed by input port
  port_sel_t [NumPorts-1:0]               route_req;
  port_sel_t [NumPorts-1:0]               grant_by_in;
  logic      [NumPorts-1:0]               in_grant;
  coord_t    [NumPorts-1:0]               head_dst_x;
  coord_t    [NumPorts-1:0]               head_dst_y;
  logic      [NumPorts-1:0][PayloadW-1:0] head_payload;

  // Indexed by output port
  port_sel_t [NumPorts-1:0]               out_req;
  port_sel_t [NumPorts-1:0]               out_grant;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    floo_in_port #(
      .PayloadW ( PayloadW )
    ) i_in_port (
      .clk_i,
      .reset_i,
      .in             ( in_link[i]      ),
      .node_x_i,
      .node_y_i,
      .route_req_o    ( route_req[i]    ),
      .head_dst_x_o   ( head_dst_x[i]   ),
      .head_dst_y_o   ( head_dst_y[i]   ),
      .head_payload_o ( head_payload[i] ),
      .grant_i        ( in_grant[i]     )
    );
    assign in_grant[i] = |grant_by_in[i];
  end

  // Requests go out per output, grants come back per input
  for (genvar o = 0; o < NumPorts; o++) begin : gen_xpose
    for (genvar i = 0; i < NumPorts; i++) begin : gen_bit
      assign out_req[o][i]     = route_req[i][o];
      assign grant_by_in[i][o] = out_grant[o][i];
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    floo_out_arbiter #(
      .PayloadW ( PayloadW )
    ) i_out_arbiter (
      .clk_i,
      .reset_i,
      .req_i          ( out_req[o]   ),
      .flit_dst_x_i   ( head_dst_x   ),
      .flit_dst_y_i   ( head_dst_y   ),
      .flit_payload_i ( head_payload ),
      .grant_o        ( out_grant[o] ),
      .out            ( out_link[o]  )
    );
  end

endmodule

// File: hw/floo_out_arbiter.sv
// --------------------
// Output port: round-robin arbiter, flit mux and output register
// --------------------

module floo_out_arbiter #(
  parameter int unsigned PayloadW = 32
) (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  floo_nw_pkg::port_sel_t                        req_i,
  input  floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0] flit_dst_x_i,
  input  floo_nw_pkg::coord_t [floo_nw_pkg::NumPorts-1:0] flit_dst_y_i,
  input  logic [floo_nw_pkg::NumPorts-1:0][PayloadW-1:0]  flit_payload_i,
  output floo_nw_pkg::port_sel_t                        grant_o,
  floo_link_if.sender                                   out
);
  import floo_nw_pkg::*;

  port_e               last_q;
  port_e               winner;
  logic                found;
  logic                load_en;
  logic                valid_q;
  coord_t              dst_x_q;
  coord_t              dst_y_q;
  logic [PayloadW-1:0] payload_q;

  // Register is free, or drains on this edge
  assign load_en = !valid_q || out.ready;

  // Search starts one past the previous winner
  always_comb begin
    int unsigned idx;
    winner = last_q;
    found  = 1'b0;
    for (int unsigned off = 1; off <= NumPorts; off++) begin
      idx = (last_q + off) % NumPorts;
      if (!found && req_i[idx]) begin
        found  = 1'b1;
        winner = port_e'(idx);
      end
    end
    grant_o = '0;
    if (found && load_en) begin
      grant_o[winner] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      last_q  <= PortWest;
    end else if (load_en) begin
      valid_q <= found;
      if (found) last_q <= winner;
    end
  end

  // Flit fields only change when a new winner is loaded
  always_ff @(posedge clk_i) begin
    if (load_en && found) begin
      dst_x_q   <= flit_dst_x_i[winner];
      dst_y_q   <= flit_dst_y_i[winner];
      payload_q <= flit_payload_i[winner];
    end
  end

  assign out.valid   = valid_q;
  assign out.dst_x   = dst_x_q;
  assign out.dst_y   = dst_y_q;
  assign out.payload = payload_q;

endmodule

// File: hw/floo_in_port.sv
// --------------------
// Input port: flit FIFO and XY route computation for the head flit
// --------------------

module floo_in_port #(
  parameter int unsigned PayloadW = 32
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  floo_link_if.receiver          in,
  input  floo_nw_pkg::coord_t    node_x_i,
  input  floo_nw_pkg::coord_t    node_y_i,
  output floo_nw_pkg::port_sel_t route_req_o,
  output floo_nw_pkg::coord_t    head_dst_x_o,
  output floo_nw_pkg::coord_t    head_dst_y_o,
  output logic [PayloadW-1:0]    head_payload_o,
  input  logic                   grant_i
);
  import floo_nw_pkg::*;

  coord_t              dst_x_q   [InFifoDepth];
  coord_t              dst_y_q   [InFifoDepth];
  logic [PayloadW-1:0] payload_q [InFifoDepth];

  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t count_q;
  logic      push;
  logic      pop;
  logic      head_valid;
  port_e     out_port;

  function automatic fifo_ptr_t next_ptr(fifo_ptr_t ptr);
    return (ptr == fifo_ptr_t'(InFifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Accept whenever a slot is free
  assign in.ready   = (count_q != fifo_cnt_t'(InFifoDepth));
  assign head_valid = (count_q != '0);
  assign push       = in.valid & in.ready;
  assign pop        = grant_i & head_valid;

  always_ff @(posedge clk_i) begin
    if (push) begin
      dst_x_q[wr_ptr_q]   <= in.dst_x;
      dst_y_q[wr_ptr_q]   <= in.dst_y;
      payload_q[wr_ptr_q] <= in.payload;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign head_dst_x_o   = dst_x_q[rd_ptr_q];
  assign head_dst_y_o   = dst_y_q[rd_ptr_q];
  assign head_payload_o = payload_q[rd_ptr_q];

  // Dimension-ordered routing, X resolved before Y
  always_comb begin
    out_port = PortLocal;
    if (head_dst_x_o > node_x_i) begin
      out_port = PortEast;
    end else if (head_dst_x_o < node_x_i) begin
      out_port = PortWest;
    end else if (head_dst_y_o > node_y_i) begin
      out_port = PortNorth;
    end else if (head_dst_y_o < node_y_i) begin
      out_port = PortSouth;
    end
    route_req_o           = '0;
    route_req_o[out_port] = head_valid;
  end

endmodule

// File: hw/floo_link_if.sv
// --------------------
// One valid/ready flit link with sender and receiver views
// --------------------

interface floo_link_if #(
  parameter int unsigned PayloadW = 32
) ();
  import floo_nw_pkg::*;

  logic                valid;
  logic                ready;
  coord_t              dst_x;
  coord_t              dst_y;
  logic [PayloadW-1:0] payload;

  modport sender (
    output valid, dst_x, dst_y, payload,
    input  ready
  );

  modport receiver (
    input  valid, dst_x, dst_y, payload,
    output ready
  );

endinterface

// File: hw/floo_nw_pkg.sv
// --------------------
// Shared router definitions: port count, coordinate and payload
// widths, flit payload types, FIFO sizing and port directions
// --------------------

package floo_nw_pkg;

  localparam int unsigned NumPorts = 5;
  localparam int unsigned CoordW   = 3;

  // Payload widths of the three physical networks
  localparam int unsigned ReqPayloadW  = 32;
  localparam int unsigned RspPayloadW  = 16;
  localparam int unsigned WidePayloadW = 128;

  // Input buffer sizing
  localparam int unsigned InFifoDepth = 2;
  localparam int unsigned FifoPtrW    = (InFifoDepth > 1) ? $clog2(InFifoDepth) : 1;
  localparam int unsigned FifoCntW    = $clog2(InFifoDepth + 1);

  typedef logic [CoordW-1:0]       coord_t;
  typedef logic [NumPorts-1:0]     port_sel_t;
  typedef logic [FifoPtrW-1:0]     fifo_ptr_t;
  typedef logic [FifoCntW-1:0]     fifo_cnt_t;

  typedef logic [ReqPayloadW-1:0]  req_payload_t;
  typedef logic [RspPayloadW-1:0]  rsp_payload_t;
  typedef logic [WidePayloadW-1:0] wide_payload_t;

  // Port directions, also the output-port index
  typedef enum logic [2:0] {
    PortLocal = 3'd0,
    PortNorth = 3'd1,
    PortEast  = 3'd2,
    PortSouth = 3'd3,
    PortWest  = 3'd4
  } port_e;

endpackage
